/* ball_window.sv */
`default_nettype none
`timescale 1ns/1ps
`include "video_overlay_config.svh"

module ball_window (
    input  video_overlay_pkg::coord_t     x_pixel,
    input  video_overlay_pkg::coord_t     y_pixel,
    input  video_overlay_pkg::coord_t     ball_x,
    input  video_overlay_pkg::coord_t     ball_y,
    input  video_overlay_pkg::ball_size_e rand_ball,
    output logic                          ball_area,
    output logic [5:0]                    x_offset,
    output logic [5:0]                    y_offset
);
    import video_overlay_pkg::*;

    logic [6:0] size_px;
    coord_t     dx;
    coord_t     dy;

    always_comb begin
        case (rand_ball)
            BALL_SMALL:  size_px = 7'(`BALL_SMALL_PX);
            BALL_MEDIUM: size_px = 7'(`BALL_MEDIUM_PX);
            default:     size_px = 7'(`BALL_LARGE_PX);
        endcase
    end

    assign dx = x_pixel - ball_x;
    assign dy = y_pixel - ball_y;

    // difference compare avoids overflow near the right and bottom edge
    assign ball_area = (x_pixel >= ball_x) && (dx < coord_t'(size_px)) &&
                       (y_pixel >= ball_y) && (dy < coord_t'(size_px));

    // address into the 64x64 ball rom, valid in this same cycle
    assign x_offset = dx[5:0];
    assign y_offset = dy[5:0];

endmodule

`default_nettype wire

/* banner_text.sv */
`default_nettype none
`timescale 1ns/1ps
`include "video_overlay_config.svh"

module banner_text (
    input  video_overlay_pkg::coord_t x_pixel,
    input  video_overlay_pkg::coord_t y_pixel,
    input  logic                      game_over,
    input  logic                      player_1or2,
    output logic                      banner_lit
);
    import video_overlay_pkg::*;

    localparam int CELL_W = `GLYPH_W * `TEXT_SCALE;
    localparam int BOX_H  = `GLYPH_H * `TEXT_SCALE;
    localparam int GO_W   = 9 * CELL_W;
    localparam int LOSE_W = 4 * CELL_W;

    coord_t     org_x;
    coord_t     org_y;
    coord_t     box_w;
    coord_t     dx;
    coord_t     dy;
    logic       in_box;
    logic [3:0] idx;
    logic [2:0] row;
    logic [2:0] col;
    ascii_t     ch;
    glyph_row_t bits;

    function automatic ascii_t go_char(input logic [3:0] i);
        case (i)
            4'd0:    return 8'h47;
            4'd1:    return 8'h41;
            4'd2:    return 8'h4D;
            4'd3:    return 8'h45;
            4'd5:    return 8'h4F;
            4'd6:    return 8'h56;
            4'd7:    return 8'h45;
            4'd8:    return 8'h52;
            default: return 8'h20;
        endcase
    endfunction

    function automatic ascii_t lose_char(input logic [3:0] i);
        case (i)
            4'd0:    return 8'h4C;
            4'd1:    return 8'h4F;
            4'd2:    return 8'h53;
            4'd3:    return 8'h45;
            default: return 8'h20;
        endcase
    endfunction

    // one player sees GAME OVER, two players see LOSE
    always_comb begin
        if (player_1or2) begin
            org_x = coord_t'(`LOSE_X);
            org_y = coord_t'(`LOSE_Y);
            box_w = coord_t'(LOSE_W);
        end else begin
            org_x = coord_t'(`GO_X);
            org_y = coord_t'(`GO_Y);
            box_w = coord_t'(GO_W);
        end
    end

    assign dx = x_pixel - org_x;
    assign dy = y_pixel - org_y;

    assign in_box = (x_pixel >= org_x) && (dx < box_w) &&
                    (y_pixel >= org_y) && (dy < coord_t'(BOX_H));

    assign idx = 4'(dx / coord_t'(CELL_W));
    assign col = 3'((dx % coord_t'(CELL_W)) / coord_t'(`TEXT_SCALE));
    assign row = 3'(dy / coord_t'(`TEXT_SCALE));
    assign ch  = player_1or2 ? lose_char(idx) : go_char(idx);

    glyph_rom u_glyph_rom (
        .ch   (ch),
        .row  (row),
        .bits (bits)
    );

    assign banner_lit = game_over && in_box && bits[3'd7 - col];

endmodule

`default_nettype wire

/* glyph_rom.sv */
`default_nettype none
`timescale 1ns/1ps
`include "video_overlay_config.svh"

module glyph_rom (
    input  video_overlay_pkg::ascii_t     ch,
    input  logic [2:0]                    row,
    output video_overlay_pkg::glyph_row_t bits
);
    import video_overlay_pkg::*;

    // row 0 sits in the top byte
    glyph_row_t [0:`GLYPH_H-1] glyph;

    always_comb begin
        case (ch)
            // digits
            8'h30: glyph = 64'h3C66_6E76_6666_3C00;
            8'h31: glyph = 64'h1838_1818_1818_7E00;
            8'h32: glyph = 64'h3C66_060C_3060_7E00;
            8'h33: glyph = 64'h3C66_061C_0666_3C00;
            8'h34: glyph = 64'h0C1C_3C6C_7E0C_0C00;
            8'h35: glyph = 64'h7E60_7C06_0666_3C00;
            8'h36: glyph = 64'h3C60_7C66_6666_3C00;
            8'h37: glyph = 64'h7E06_0C18_3030_3000;
            8'h38: glyph = 64'h3C66_663C_6666_3C00;
            8'h39: glyph = 64'h3C66_663E_0606_3C00;
            // letters for GAME OVER
            8'h47: glyph = 64'h3C66_606E_6666_3C00;
            8'h41: glyph = 64'h183C_6666_7E66_6600;
            8'h4D: glyph = 64'h6377_7F6B_6363_6300;
            8'h45: glyph = 64'h7E60_607C_6060_7E00;
            8'h4F: glyph = 64'h3C66_6666_6666_3C00;
            8'h56: glyph = 64'h6666_6666_663C_1800;
            8'h52: glyph = 64'h7C66_667C_6C66_6600;
            // extra letters for LOSE
            8'h4C: glyph = 64'h6060_6060_6060_7E00;
            8'h53: glyph = 64'h3E60_603C_0606_7C00;
            // space and anything unknown stay dark
            default: glyph = '0;
        endcase
    end

    assign bits = glyph[row];

endmodule

`default_nettype wire

/* pixel_mixer.sv */
`default_nettype none
`timescale 1ns/1ps
`include "video_overlay_config.svh"

module pixel_mixer (
    input  logic                      pclk,
    input  logic                      arst_n,
    input  video_overlay_pkg::rgb565_t camera_pixel,
    input  video_overlay_pkg::rgb565_t rom_pixel,
    input  logic                      game_over,
    input  logic                      ball_send_trigger,
    input  logic                      banner_lit,
    input  logic                      ball_area,
    input  logic                      score_box,
    input  logic                      score_lit,
    output logic [3:0]                red,
    output logic [3:0]                green,
    output logic [3:0]                blue,
    output logic                      is_hit_area
);
    import video_overlay_pkg::*;

    rgb565_t mix_pixel;

    // banner over ball over score over camera
    always_comb begin
        if (banner_lit) begin
            mix_pixel = `BANNER_COLOR;
        end else if (ball_area && rom_pixel != `KEY_COLOR) begin
            // ball hides behind the video while a throw is sent or the game is over
            mix_pixel = (game_over || ball_send_trigger) ? camera_pixel : rom_pixel;
        end else if (score_box) begin
            mix_pixel = score_lit ? `TEXT_COLOR : '0;
        end else begin
            mix_pixel = camera_pixel;
        end
    end

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            red         <= '0;
            green       <= '0;
            blue        <= '0;
            is_hit_area <= 1'b0;
        end else begin
            red         <= mix_pixel[15:12];
            green       <= mix_pixel[10:7];
            blue        <= mix_pixel[4:1];
            is_hit_area <= ball_area;
        end
    end

    // banner_text must gate its pixels with game_over
    a_banner_needs_game_over: assert property (@(posedge pclk) disable iff (!arst_n)
        banner_lit |-> game_over)
        else $error("banner lit while game_over is low");

    // score_text lights nothing outside its own box
    a_score_lit_in_box: assert property (@(posedge pclk) disable iff (!arst_n)
        score_lit |-> score_box)
        else $error("score pixel lit outside the score box");

    // first edge out of reset still shows the cleared outputs
    a_reset_outputs_zero: assert property (@(posedge pclk)
        $rose(arst_n) |-> (red == 4'h0 && green == 4'h0 && blue == 4'h0 && !is_hit_area))
        else $error("outputs not cleared by reset");

endmodule

`default_nettype wire

/* project.f */
+incdir+.
video_overlay_pkg.sv
glyph_rom.sv
score_text.sv
banner_text.sv
ball_window.sv
pixel_mixer.sv
video_overlay.sv
tb_video_overlay.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_video_overlay -f project.f -o tb_video_overlay
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit "$status"
fi

./obj_dir/tb_video_overlay
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed"
fi
exit "$status"

/* score_text.sv */
`default_nettype none
`timescale 1ns/1ps
`include "video_overlay_config.svh"

module score_text (
    input  video_overlay_pkg::coord_t x_pixel,
    input  video_overlay_pkg::coord_t y_pixel,
    input  logic [7:0]                score,
    output logic                      score_box,
    output logic                      score_lit
);
    import video_overlay_pkg::*;

    localparam int CELL_W = `GLYPH_W * `TEXT_SCALE;
    localparam int BOX_W  = 2 * CELL_W;
    localparam int BOX_H  = `GLYPH_H * `TEXT_SCALE;

    logic [3:0] digit_tens;
    logic [3:0] digit_ones;
    ascii_t     ch;
    coord_t     dx;
    coord_t     dy;
    logic       ones_cell;
    logic [2:0] row;
    logic [2:0] col;
    glyph_row_t bits;

    assign digit_tens = 4'(score / 8'd10);
    assign digit_ones = 4'(score % 8'd10);

    assign dx = x_pixel - coord_t'(`SCORE_X);
    assign dy = y_pixel - coord_t'(`SCORE_Y);

    assign score_box = (x_pixel >= coord_t'(`SCORE_X)) && (dx < coord_t'(BOX_W)) &&
                       (y_pixel >= coord_t'(`SCORE_Y)) && (dy < coord_t'(BOX_H));

    // left cell is tens, right cell is ones
    assign ones_cell = (dx >= coord_t'(CELL_W));
    assign ch = 8'h30 + (ones_cell ? {4'h0, digit_ones} : {4'h0, digit_tens});

    // each glyph pixel covers a 2x2 block on screen
    assign col = 3'((dx % coord_t'(CELL_W)) / coord_t'(`TEXT_SCALE));
    assign row = 3'(dy / coord_t'(`TEXT_SCALE));

    glyph_rom u_glyph_rom (
        .ch   (ch),
        .row  (row),
        .bits (bits)
    );

    assign score_lit = score_box && bits[3'd7 - col];

endmodule

`default_nettype wire

/* tb_video_overlay.sv */
`default_nettype none
`timescale 1ns/1ps
`include "video_overlay_config.svh"

module tb_video_overlay;
    import video_overlay_pkg::*;

    logic       pclk;
    logic       arst_n;
    logic       player_1or2;
    coord_t     x_pixel;
    coord_t     y_pixel;
    rgb565_t    camera_pixel;
    rgb565_t    rom_pixel;
    logic [7:0] score;
    coord_t     ball_x;
    coord_t     ball_y;
    logic       game_over;
    logic       ball_send_trigger;
    ball_size_e rand_ball;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic [5:0] x_offset;
    logic [5:0] y_offset;
    logic       is_hit_area;

    // model state behind the next driven pixel
    int          cur_bx;
    int          cur_by;
    logic [1:0]  cur_size;
    bit          cur_over;
    bit          cur_trig;
    bit          cur_player;
    logic [31:0] rng = 32'd86;
    int          cycle_count = 0;

    // expected {red, green, blue, hit} and the cycle it is due
    logic [12:0] exp_q[$];
    string       name_q[$];
    int          due_q[$];

    video_overlay u_video_overlay (.*);

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    always @(posedge pclk) cycle_count <= cycle_count + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift32(rng);
        return int'(rng % 32'(n));
    endfunction

    function automatic rgb565_t rand_pixel();
        return 16'(rand_below(65536));
    endfunction

    // column 0 is the msb of a font row
    function automatic bit lit_col(input logic [7:0] row_bits, input int col);
        return row_bits[7 - col];
    endfunction

    // glyph_bit is the font bit under the pixel in whichever text box holds it
    function automatic logic [12:0] expected_pixel(input int x, input int y,
            input rgb565_t cam, input rgb565_t rom, input int bx, input int by,
            input logic [1:0] size_sel, input bit over, input bit trig, input bit player,
            input bit glyph_bit);
        int      edge_px;
        int      org_x;
        int      org_y;
        int      box_w;
        bit      in_ball;
        bit      in_score;
        bit      in_banner;
        rgb565_t pix;
        edge_px = (size_sel == 2'd0) ? `BALL_SMALL_PX :
                  (size_sel == 2'd1) ? `BALL_MEDIUM_PX : `BALL_LARGE_PX;
        org_x = player ? `LOSE_X : `GO_X;
        org_y = player ? `LOSE_Y : `GO_Y;
        box_w = (player ? 4 : 9) * `GLYPH_W * `TEXT_SCALE;
        in_ball = x >= bx && x < bx + edge_px && y >= by && y < by + edge_px;
        in_score = x >= `SCORE_X && x < `SCORE_X + 2 * `GLYPH_W * `TEXT_SCALE &&
                   y >= `SCORE_Y && y < `SCORE_Y + `GLYPH_H * `TEXT_SCALE;
        in_banner = over && x >= org_x && x < org_x + box_w &&
                    y >= org_y && y < org_y + `GLYPH_H * `TEXT_SCALE;
        if (in_banner && glyph_bit)
            pix = `BANNER_COLOR;
        else if (in_ball && rom != `KEY_COLOR)
            pix = (over || trig) ? cam : rom;
        else if (in_score)
            pix = glyph_bit ? `TEXT_COLOR : 16'h0000;
        else
            pix = cam;
        return {pix[15:12], pix[10:7], pix[4:1], in_ball};
    endfunction

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic drive_pixel(input string name, input int x, input int y,
                               input rgb565_t cam, input rgb565_t rom, input bit glyph_bit);
        @(posedge pclk);
        x_pixel           <= 10'(x);
        y_pixel           <= 10'(y);
        camera_pixel      <= cam;
        rom_pixel         <= rom;
        ball_x            <= 10'(cur_bx);
        ball_y            <= 10'(cur_by);
        rand_ball         <= ball_size_e'(cur_size);
        game_over         <= cur_over;
        ball_send_trigger <= cur_trig;
        player_1or2       <= cur_player;
        exp_q.push_back(expected_pixel(x, y, cam, rom, cur_bx, cur_by, cur_size,
                                       cur_over, cur_trig, cur_player, glyph_bit));
        name_q.push_back(name);
        due_q.push_back(cycle_count + 2);
    endtask

    // offsets are combinational and checked in the drive cycle
    task automatic ball_pixel(input string name, input int dx, input int dy, input bit opaque);
        rgb565_t rom;
        rom = opaque ? (rand_pixel() | 16'h1000) : `KEY_COLOR;
        drive_pixel(name, cur_bx + dx, cur_by + dy, rand_pixel(), rom, 1'b0);
        @(negedge pclk);
        compare_value({name, ".x_offset"}, {10'd0, 6'(dx)}, 16'(x_offset));
        compare_value({name, ".y_offset"}, {10'd0, 6'(dy)}, 16'(y_offset));
    endtask

    initial begin
        logic [12:0] exp_val;
        string       tname;
        forever begin
            @(negedge pclk);
            while (due_q.size() > 0 && due_q[0] == cycle_count) begin
                exp_val = exp_q.pop_front();
                tname   = name_q.pop_front();
                void'(due_q.pop_front());
                compare_value({tname, ".red"}, 16'(exp_val[12:9]), 16'(red));
                compare_value({tname, ".green"}, 16'(exp_val[8:5]), 16'(green));
                compare_value({tname, ".blue"}, 16'(exp_val[4:1]), 16'(blue));
                compare_value({tname, ".hit"}, 16'(exp_val[0]), 16'(is_hit_area));
            end
        end
    end

    initial begin
        int i;
        int j;
        int s;
        int e;
        arst_n            = 1'b0;
        player_1or2       = 1'b0;
        x_pixel           = '0;
        y_pixel           = '0;
        camera_pixel      = 16'hFFFF;
        rom_pixel         = 16'h0000;
        score             = 8'd10;
        ball_x            = '0;
        ball_y            = '0;
        game_over         = 1'b0;
        ball_send_trigger = 1'b0;
        rand_ball         = BALL_SMALL;
        cur_bx = 0;
        cur_by = 0;
        cur_size = 2'd0;
        cur_over = 1'b0;
        cur_trig = 1'b0;
        cur_player = 1'b0;

        for (i = 0; i < 3; i++) begin
            @(posedge pclk);
            if (i == 2)
                arst_n <= 1'b1;
            @(negedge pclk);
            compare_value("reset.red", 16'h0, 16'(red));
            compare_value("reset.green", 16'h0, 16'(green));
            compare_value("reset.blue", 16'h0, 16'(blue));
            compare_value("reset.hit", 16'h0, 16'(is_hit_area));
        end

        // below the text and away from the ball
        for (i = 0; i < 20; i++)
            drive_pixel("camera", rand_below(640), 300 + rand_below(180),
                        rand_pixel(), rand_pixel(), 1'b0);

        for (s = 0; s < 4; s++) begin
            cur_size = 2'(s);
            e = (s == 0) ? `BALL_SMALL_PX : (s == 1) ? `BALL_MEDIUM_PX : `BALL_LARGE_PX;
            cur_bx = 1 + rand_below(500);
            cur_by = 300 + rand_below(100);
            ball_pixel("ball.in_top_left", 0, 0, 1'b1);
            ball_pixel("ball.in_bottom_right", e - 1, e - 1, 1'b1);
            ball_pixel("ball.in_random", rand_below(e), rand_below(e), 1'b1);
            ball_pixel("ball.out_left", -1, 0, 1'b1);
            ball_pixel("ball.out_right", e, e - 1, 1'b1);
            ball_pixel("ball.out_top", 0, -1, 1'b1);
            ball_pixel("ball.out_bottom", e - 1, e, 1'b1);
            ball_pixel("ball.key_color", 1, 1, 1'b0);
            cur_trig = 1'b1;
            ball_pixel("ball.send_trigger", 2, 2, 1'b1);
            cur_trig = 1'b0;
            cur_over = 1'b1;
            ball_pixel("ball.game_over", 3, 3, 1'b1);
            cur_over = 1'b0;
        end
        cur_bx = 0;
        cur_by = 0;
        cur_size = 2'd0;

        // row 6 of digit 1 is 0x7e
        for (i = 0; i < 16; i++)
            for (j = 0; j < 2; j++)
                drive_pixel("score.tens_row6", `SCORE_X + i, 52 + j, rand_pixel(),
                            rand_pixel(), lit_col(8'h7E, i / 2));
        for (i = 0; i < 32; i++)
            for (j = 0; j < 2; j++)
                drive_pixel("score.row7", `SCORE_X + i, 54 + j, rand_pixel(),
                            rand_pixel(), 1'b0);
        drive_pixel("score.outside", `SCORE_X - 1, 52, rand_pixel(), rand_pixel(), 1'b0);
        drive_pixel("score.outside", `SCORE_X + 32, 52, rand_pixel(), rand_pixel(), 1'b0);
        drive_pixel("score.outside", `SCORE_X + 10, `SCORE_Y - 1, rand_pixel(),
                    rand_pixel(), 1'b0);
        drive_pixel("score.outside", `SCORE_X + 10, `SCORE_Y + 16, rand_pixel(),
                    rand_pixel(), 1'b0);

        cur_over = 1'b1;
        cur_player = 1'b0;
        for (i = 0; i < 16; i++)
            for (j = 0; j < 2; j++)
                drive_pixel("banner.g_row0", `GO_X + i, `GO_Y + j, rand_pixel(), rand_pixel(),
                            lit_col(8'h3C, i / 2));
        // gap between GAME and OVER
        for (i = 0; i < 16; i++)
            for (j = 0; j < 16; j++)
                drive_pixel("banner.space", `GO_X + 4 * `GLYPH_W * `TEXT_SCALE + i, `GO_Y + j,
                            rand_pixel(), rand_pixel(), 1'b0);
        cur_over = 1'b0;
        for (i = 4; i < 12; i++)
            drive_pixel("banner.cleared", `GO_X + i, `GO_Y, rand_pixel(), rand_pixel(),
                        lit_col(8'h3C, i / 2));

        cur_over = 1'b1;
        cur_player = 1'b1;
        for (i = 0; i < 16; i++)
            for (j = 0; j < 2; j++)
                drive_pixel("lose.o_row0", `LOSE_X + 16 + i, `LOSE_Y + j, rand_pixel(),
                            rand_pixel(), lit_col(8'h3C, i / 2));
        for (i = `GO_X; i < `LOSE_X; i++)
            for (j = 0; j < 16; j++)
                drive_pixel("lose.left_of_box", i, `GO_Y + j, rand_pixel(), rand_pixel(), 1'b0);
        // medium ball laid over the O cell
        cur_bx = `LOSE_X + 16;
        cur_by = `LOSE_Y - 4;
        cur_size = 2'd1;
        drive_pixel("lose.banner_over_ball", cur_bx + 4, `LOSE_Y, rand_pixel(),
                    rand_pixel() | 16'h1000, 1'b1);
        drive_pixel("lose.dark_in_ball", cur_bx, `LOSE_Y, rand_pixel(),
                    rand_pixel() | 16'h1000, 1'b0);

        for (i = 0; i < 10 && due_q.size() != 0; i++)
            @(posedge pclk);
        if (due_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("timeout while waiting for the last pixels to be compared");
            $display("Some tests failed");
            $fatal(1, "run stopped on timeout");
        end
    end

endmodule

`default_nettype wire

/* video_overlay.sv */
`default_nettype none
`timescale 1ns/1ps

module video_overlay (
    input  logic                          pclk,
    input  logic                          arst_n,
    input  logic                          player_1or2,
    input  video_overlay_pkg::coord_t     x_pixel,
    input  video_overlay_pkg::coord_t     y_pixel,
    input  video_overlay_pkg::rgb565_t    camera_pixel,
    input  video_overlay_pkg::rgb565_t    rom_pixel,
    input  logic [7:0]                    score,
    input  video_overlay_pkg::coord_t     ball_x,
    input  video_overlay_pkg::coord_t     ball_y,
    input  logic                          game_over,
    input  logic                          ball_send_trigger,
    input  video_overlay_pkg::ball_size_e rand_ball,
    output logic [3:0]                    red,
    output logic [3:0]                    green,
    output logic [3:0]                    blue,
    output logic [5:0]                    x_offset,
    output logic [5:0]                    y_offset,
    output logic                          is_hit_area
);

    logic score_box;
    logic score_lit;
    logic banner_lit;
    logic ball_area;

    score_text u_score_text (
        .x_pixel   (x_pixel),
        .y_pixel   (y_pixel),
        .score     (score),
        .score_box (score_box),
        .score_lit (score_lit)
    );

    banner_text u_banner_text (
        .x_pixel     (x_pixel),
        .y_pixel     (y_pixel),
        .game_over   (game_over),
        .player_1or2 (player_1or2),
        .banner_lit  (banner_lit)
    );

    // offsets go straight out to the external ball rom
    ball_window u_ball_window (
        .x_pixel   (x_pixel),
        .y_pixel   (y_pixel),
        .ball_x    (ball_x),
        .ball_y    (ball_y),
        .rand_ball (rand_ball),
        .ball_area (ball_area),
        .x_offset  (x_offset),
        .y_offset  (y_offset)
    );

    pixel_mixer u_pixel_mixer (
        .pclk              (pclk),
        .arst_n            (arst_n),
        .camera_pixel      (camera_pixel),
        .rom_pixel         (rom_pixel),
        .game_over         (game_over),
        .ball_send_trigger (ball_send_trigger),
        .banner_lit        (banner_lit),
        .ball_area         (ball_area),
        .score_box         (score_box),
        .score_lit         (score_lit),
        .red               (red),
        .green             (green),
        .blue              (blue),
        .is_hit_area       (is_hit_area)
    );

endmodule

`default_nettype wire

/* video_overlay_config.svh */
`ifndef VIDEO_OVERLAY_CONFIG_SVH
`define VIDEO_OVERLAY_CONFIG_SVH

// score box origin for two digits side by side
`define SCORE_X 500
`define SCORE_Y 40

// font cell before scaling
`define GLYPH_W 8
`define GLYPH_H 8
`define TEXT_SCALE 2

// end of game banners
`define GO_X 250
`define GO_Y 200
`define LOSE_X 280
`define LOSE_Y 200

// ball edge lengths per rand_ball
`define BALL_SMALL_PX 20
`define BALL_MEDIUM_PX 40
`define BALL_LARGE_PX 64

// rgb565 colours
`define TEXT_COLOR 16'hFFFF
`define BANNER_COLOR 16'hF001
// rom pixels of this value are see-through
`define KEY_COLOR 16'h0000

`endif

/* video_overlay_pkg.sv */
`default_nettype none

package video_overlay_pkg;

    // red 15:12, green 10:7, blue 4:1 reach the 4-bit dac
    typedef logic [15:0] rgb565_t;

    // vga scan position
    typedef logic [9:0] coord_t;

    typedef logic [7:0] ascii_t;

    // msb is the leftmost pixel of the row
    typedef logic [7:0] glyph_row_t;

    // value 3 also selects the large ball
    typedef enum logic [1:0] {
        BALL_SMALL  = 2'd0,
        BALL_MEDIUM = 2'd1,
        BALL_LARGE  = 2'd2
    } ball_size_e;

endpackage

`default_nettype wire
